// ==== hw/core_pkg.sv ====
// Core-wide definitions
// Bus widths, register count, pipeline hold codes and data port direction

package core_pkg;

	// ************************************************************
	// Widths and sizes
	// ************************************************************
	localparam int XLEN       = 32;  // Data and address width
	localparam int REG_ADDR_W = 5;   // Register index width
	localparam int REG_NUM    = 32;  // Number of integer registers

	// ************************************************************
	// Pipeline control
	// ************************************************************

	// HOLD_ID freezes the pc and sends a bubble into execute
	typedef enum logic [1:0] {
		HOLD_NONE = 2'b00,
		HOLD_ID   = 2'b01
	} hold_code_t;

	// Direction of the data memory port
	typedef enum logic {
		MEM_RD = 1'b0,
		MEM_WR = 1'b1
	} mem_state_t;

endpackage

// ==== hw/isa_pkg.sv ====
// Instruction set definitions for the supported RV32I subset
// Opcodes, funct3 values, ALU operations and jump flags

package isa_pkg;

	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL     = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;

	localparam logic [31:0] INSTR_NOP = 32'h0000_0013;  // ADDI x0, x0, 0

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_PASSB
	} alu_op_t;

	typedef enum logic [1:0] {
		JMP_NONE, JMP_BEQ, JMP_BNE, JMP_JAL
	} jmp_flag_t;

endpackage

// ==== hw/pc.sv ====
// Program counter
// Loads a jump target, holds on a load-use stall, else steps by one word

`timescale 1ns/1ns

module pc import core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
	input  logic            clk,
	input  logic            arst_n_i,
	input  hold_code_t      hold_code_i,
	input  logic            jmp_en_i,
	input  logic [XLEN-1:0] jmp_to_i,
	output logic [XLEN-1:0] pc_o
);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= RESET_ADDR;
		end else if (jmp_en_i) begin
			pc_o <= jmp_to_i;  // Redirect wins over the hold
		end else if (hold_code_i != HOLD_ID) begin
			pc_o <= pc_o + XLEN'(4);
		end
	end

	// Branch and JAL targets come from decode immediates and must stay on word boundaries
	a_jmp_aligned: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		jmp_en_i |-> (jmp_to_i[1:0] == 2'b00)
	);

endmodule

// ==== hw/id_stage.sv ====
// Decode stage
// Fetch masking, decode of the RV32I subset, immediates, operand forwarding
// and the decode/execute pipeline register

`timescale 1ns/1ns

module id_stage import core_pkg::*, isa_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  hold_code_t            hold_code_i,
	input  logic                  instr_mask_i,
	input  logic [XLEN-1:0]       instr_i,
	input  logic [XLEN-1:0]       addr_instr_i,
	input  logic [XLEN-1:0]       data_rs1_i,
	input  logic [XLEN-1:0]       data_rs2_i,
	input  logic [XLEN-1:0]       data_bypass_i,
	input  logic [REG_ADDR_W-1:0] ex_wr_addr_i,
	input  logic                  ex_wr_en_i,
	input  logic                  ex_is_load_i,
	output logic [REG_ADDR_W-1:0] addr_rs1_o,
	output logic [REG_ADDR_W-1:0] addr_rs2_o,
	output logic                  instr_rd_en_o,
	output alu_op_t               alu_operation_o,
	output logic [XLEN-1:0]       alu_op_num1_o,
	output logic [XLEN-1:0]       alu_op_num2_o,
	output logic [XLEN-1:0]       store_data_o,
	output logic                  load_o,
	output logic                  store_o,
	output logic [REG_ADDR_W-1:0] addr_wr_o,
	output logic                  reg_wr_en_o,
	output jmp_flag_t             jmp_flag_o,
	output logic [XLEN-1:0]       jmp_op_num1_o,
	output logic [XLEN-1:0]       jmp_op_num2_o,
	output logic [XLEN-1:0]       jmpb_rs1_o,
	output logic [XLEN-1:0]       jmpb_rs2_o,
	output logic                  load_bypass_o
);

	logic [XLEN-1:0]       instr_word;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
	logic                  fwd_rs1, fwd_rs2;
	logic [XLEN-1:0]       rs1_val, rs2_val;
	logic                  use_rs1, use_rs2;
	logic                  known_op;
	logic                  bubble;
	alu_op_t               dec_alu_op;
	logic [XLEN-1:0]       dec_num1, dec_num2, dec_jmp1, dec_jmp2;
	logic                  dec_load, dec_store, dec_wr_en;
	jmp_flag_t             dec_jmp_flag;

	// The slot behind a taken jump decodes as a NOP
	assign instr_word = instr_mask_i ? INSTR_NOP : instr_i;
	assign opcode     = instr_word[6:0];
	assign rd         = instr_word[11:7];
	assign funct3     = instr_word[14:12];
	assign funct7     = instr_word[31:25];
	assign addr_rs1_o = instr_word[19:15];
	assign addr_rs2_o = instr_word[24:20];

	assign bubble        = (hold_code_i == HOLD_ID);
	assign instr_rd_en_o = !bubble;

	assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
	assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
	assign imm_b = {{19{instr_word[31]}}, instr_word[31], instr_word[7],
		instr_word[30:25], instr_word[11:8], 1'b0};
	assign imm_u = {instr_word[31:12], 12'b0};
	assign imm_j = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
		instr_word[20], instr_word[30:21], 1'b0};

	// Execute result is newer than the register file
	assign fwd_rs1 = ex_wr_en_i && (ex_wr_addr_i == addr_rs1_o);
	assign fwd_rs2 = ex_wr_en_i && (ex_wr_addr_i == addr_rs2_o);
	assign rs1_val = fwd_rs1 ? data_bypass_i : data_rs1_i;
	assign rs2_val = fwd_rs2 ? data_bypass_i : data_rs2_i;

	// Load data only arrives in execute, so a dependent instruction must wait
	assign load_bypass_o = ex_is_load_i && ((use_rs1 && fwd_rs1) || (use_rs2 && fwd_rs2));

	// Legal words of the supported subset
	assign known_op = ((opcode == OP_REG) && (funct3[2:1] != 2'b01))
		|| ((opcode == OP_IMM) && (funct3 == F3_ADD_SUB))
		|| (opcode == OP_LUI) || (opcode == OP_JAL)
		|| (((opcode == OP_LOAD) || (opcode == OP_STORE)) && (funct3 == F3_WORD))
		|| ((opcode == OP_BRANCH) && ((funct3 == F3_BEQ) || (funct3 == F3_BNE)));

	// ************************************************************
	// Decode
	// ************************************************************
	always_comb begin
		use_rs1      = 1'b0;
		use_rs2      = 1'b0;
		dec_alu_op   = ALU_ADD;
		dec_num1     = rs1_val;
		dec_num2     = rs2_val;
		dec_load     = 1'b0;
		dec_store    = 1'b0;
		dec_wr_en    = 1'b0;
		dec_jmp_flag = JMP_NONE;
		dec_jmp1     = addr_instr_i;
		dec_jmp2     = imm_b;
		case (opcode)
			OP_REG: begin
				dec_wr_en = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				case (funct3)
					F3_ADD_SUB: begin
						if (funct7[5]) dec_alu_op = ALU_SUB;
						else dec_alu_op = ALU_ADD;
					end
					F3_SLL: dec_alu_op = ALU_SLL;
					F3_XOR: dec_alu_op = ALU_XOR;
					F3_SRL: dec_alu_op = ALU_SRL;
					F3_OR:  dec_alu_op = ALU_OR;
					F3_AND: dec_alu_op = ALU_AND;
					default: dec_wr_en = 1'b0;
				endcase
			end
			OP_IMM: if (funct3 == F3_ADD_SUB) begin  // ADDI only
				dec_wr_en = 1'b1;
				use_rs1   = 1'b1;
				dec_num2  = imm_i;
			end
			OP_LUI: begin
				dec_wr_en  = 1'b1;
				dec_alu_op = ALU_PASSB;
				dec_num2   = imm_u;
			end
			OP_LOAD: if (funct3 == F3_WORD) begin
				dec_wr_en = 1'b1;
				dec_load  = 1'b1;
				use_rs1   = 1'b1;
				dec_num2  = imm_i;
			end
			OP_STORE: if (funct3 == F3_WORD) begin
				dec_store = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				dec_num2  = imm_s;
			end
			OP_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
				use_rs1      = 1'b1;
				use_rs2      = 1'b1;
				dec_jmp_flag = (funct3 == F3_BEQ) ? JMP_BEQ : JMP_BNE;
			end
			OP_JAL: begin
				dec_wr_en    = 1'b1;
				dec_jmp_flag = JMP_JAL;
				dec_num1     = addr_instr_i;  // Link value is pc + 4
				dec_num2     = XLEN'(4);
				dec_jmp2     = imm_j;
			end
			default: ;
		endcase
		if (rd == '0) dec_wr_en = 1'b0;
	end

	// ************************************************************
	// Decode/execute register
	// ************************************************************
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			alu_operation_o <= ALU_ADD;
			load_o          <= 1'b0;
			store_o         <= 1'b0;
			addr_wr_o       <= '0;
			reg_wr_en_o     <= 1'b0;
			jmp_flag_o      <= JMP_NONE;
		end else begin
			alu_operation_o <= dec_alu_op;
			load_o          <= dec_load && !bubble;
			store_o         <= dec_store && !bubble;
			addr_wr_o       <= rd;
			reg_wr_en_o     <= dec_wr_en && !bubble;
			jmp_flag_o      <= bubble ? JMP_NONE : dec_jmp_flag;
		end
	end

	always_ff @(posedge clk) begin
		alu_op_num1_o <= dec_num1;
		alu_op_num2_o <= dec_num2;
		store_data_o  <= rs2_val;
		jmp_op_num1_o <= dec_jmp1;
		jmp_op_num2_o <= dec_jmp2;
		jmpb_rs1_o    <= rs1_val;
		jmpb_rs2_o    <= rs2_val;
	end

	// An illegal word must reach execute as a harmless bubble
	a_unknown_no_wr: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!known_op |=> !reg_wr_en_o
	);

endmodule

// ==== hw/ex_stage.sv ====
// Execute stage
// ALU, data memory address and store data, write-back selection

`timescale 1ns/1ns

module ex_stage import core_pkg::*, isa_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  alu_op_t               alu_operation_i,
	input  logic [XLEN-1:0]       alu_op_num1_i,
	input  logic [XLEN-1:0]       alu_op_num2_i,
	input  logic [XLEN-1:0]       store_data_i,
	input  logic                  load_i,
	input  logic                  store_i,
	input  logic [REG_ADDR_W-1:0] addr_wr_i,
	input  logic                  reg_wr_en_i,
	input  logic [XLEN-1:0]       data_mem_i,
	output logic [XLEN-1:0]       alu_result_o,
	output mem_state_t            mem_state_o,
	output logic [XLEN-1:0]       addr_mem_o,
	output logic [XLEN-1:0]       data_mem_wr_o,
	output logic [REG_ADDR_W-1:0] addr_reg_wr_o,
	output logic [XLEN-1:0]       data_reg_wr_o,
	output logic                  reg_wr_en_o
);

	always_comb begin
		case (alu_operation_i)
			ALU_ADD:   alu_result_o = alu_op_num1_i + alu_op_num2_i;
			ALU_SUB:   alu_result_o = alu_op_num1_i - alu_op_num2_i;
			ALU_AND:   alu_result_o = alu_op_num1_i & alu_op_num2_i;
			ALU_OR:    alu_result_o = alu_op_num1_i | alu_op_num2_i;
			ALU_XOR:   alu_result_o = alu_op_num1_i ^ alu_op_num2_i;
			ALU_SLL:   alu_result_o = alu_op_num1_i << alu_op_num2_i[4:0];
			ALU_SRL:   alu_result_o = alu_op_num1_i >> alu_op_num2_i[4:0];
			ALU_PASSB: alu_result_o = alu_op_num2_i;  // LUI
			default:   alu_result_o = '0;
		endcase
	end

	// Loads and stores both use rs1 + imm as the address
	assign addr_mem_o    = alu_result_o;
	assign mem_state_o   = store_i ? MEM_WR : MEM_RD;
	assign data_mem_wr_o = store_data_i;

	assign addr_reg_wr_o = addr_wr_i;
	assign data_reg_wr_o = load_i ? data_mem_i : alu_result_o;
	assign reg_wr_en_o   = reg_wr_en_i;

	// A store cycle never writes back
	a_store_no_wb: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!((mem_state_o == MEM_WR) && reg_wr_en_o)
	);

endmodule

// ==== hw/regs.sv ====
// Integer register file
// 32 entries, two combinational read ports, one write port, x0 reads zero

`timescale 1ns/1ns

module regs import core_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  wr_en_i,
	input  logic [REG_ADDR_W-1:0] addr_wr_i,
	input  logic [REG_ADDR_W-1:0] addr_rd1_i,
	input  logic [REG_ADDR_W-1:0] addr_rd2_i,
	input  logic [XLEN-1:0]       data_wr_i,
	output logic [XLEN-1:0]       data_rd1_o,
	output logic [XLEN-1:0]       data_rd2_o
);

	logic [XLEN-1:0] reg_file [REG_NUM];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < REG_NUM; i++) begin
				reg_file[i] <= '0;
			end
		end else if (wr_en_i && (addr_wr_i != '0)) begin
			reg_file[addr_wr_i] <= data_wr_i;
		end
	end

	assign data_rd1_o = (addr_rd1_i == '0) ? '0 : reg_file[addr_rd1_i];
	assign data_rd2_o = (addr_rd2_i == '0) ? '0 : reg_file[addr_rd2_i];

endmodule

// ==== hw/ctrl.sv ====
// Hazard controller
// Branch resolution, jump target, instruction mask and load-use hold

`timescale 1ns/1ns

module ctrl import core_pkg::*, isa_pkg::*; (
	input  jmp_flag_t       jmp_flag_i,
	input  logic [XLEN-1:0] jmp_num1_i,
	input  logic [XLEN-1:0] jmp_num2_i,
	input  logic [XLEN-1:0] data_rs1_i,
	input  logic [XLEN-1:0] data_rs2_i,
	input  logic            load_bypass_i,
	output logic            jmp_en_o,
	output logic [XLEN-1:0] jmp_to_o,
	output logic            instr_mask_o,
	output hold_code_t      hold_code_o
);

	always_comb begin
		case (jmp_flag_i)
			JMP_BEQ: jmp_en_o = (data_rs1_i == data_rs2_i);
			JMP_BNE: jmp_en_o = (data_rs1_i != data_rs2_i);
			JMP_JAL: jmp_en_o = 1'b1;
			default: jmp_en_o = 1'b0;
		endcase
	end

	assign jmp_to_o = jmp_num1_i + jmp_num2_i;  // pc + offset

	// The word fetched behind a taken jump is dropped
	assign instr_mask_o = jmp_en_o;

	// A masked instruction needs no hold
	assign hold_code_o = (load_bypass_i && !jmp_en_o) ? HOLD_ID : HOLD_NONE;

endmodule

// ==== hw/core.sv ====
// Core top level
// Connects pc, decode, execute, register file and hazard controller

`timescale 1ns/1ns

module core import core_pkg::*, isa_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic [XLEN-1:0] instr_i,
	input  logic [XLEN-1:0] addr_instr_i,
	input  logic [XLEN-1:0] data_mem_i,
	output mem_state_t      mem_state_o,
	output logic            instr_rd_en_o,
	output logic [XLEN-1:0] data_mem_wr_o,
	output logic [XLEN-1:0] addr_mem_o,
	output logic [XLEN-1:0] pc_o
);

	hold_code_t            hold_code;
	logic                  jmp_en, instr_mask, load_bypass;
	logic [XLEN-1:0]       jmp_to;
	logic [REG_ADDR_W-1:0] addr_rs1, addr_rs2, addr_wr, wb_addr;
	logic [XLEN-1:0]       data_rs1, data_rs2, alu_result, wb_data;
	alu_op_t               alu_operation;
	logic [XLEN-1:0]       alu_op_num1, alu_op_num2, store_data;
	logic                  load, store, reg_wr_en, wb_en;
	jmp_flag_t             jmp_flag;
	logic [XLEN-1:0]       jmp_op_num1, jmp_op_num2, jmpb_rs1, jmpb_rs2;

	pc #(.RESET_ADDR(RESET_ADDR)) core_pc (
		.clk(clk), .arst_n_i(arst_n_i), .hold_code_i(hold_code),
		.jmp_en_i(jmp_en), .jmp_to_i(jmp_to), .pc_o(pc_o)
	);

	id_stage core_id (
		.clk(clk), .arst_n_i(arst_n_i), .hold_code_i(hold_code),
		.instr_mask_i(instr_mask), .instr_i(instr_i), .addr_instr_i(addr_instr_i),
		.data_rs1_i(data_rs1), .data_rs2_i(data_rs2), .data_bypass_i(alu_result),
		.ex_wr_addr_i(wb_addr), .ex_wr_en_i(wb_en), .ex_is_load_i(load),
		.addr_rs1_o(addr_rs1), .addr_rs2_o(addr_rs2), .instr_rd_en_o(instr_rd_en_o),
		.alu_operation_o(alu_operation), .alu_op_num1_o(alu_op_num1),
		.alu_op_num2_o(alu_op_num2), .store_data_o(store_data), .load_o(load),
		.store_o(store), .addr_wr_o(addr_wr), .reg_wr_en_o(reg_wr_en),
		.jmp_flag_o(jmp_flag), .jmp_op_num1_o(jmp_op_num1), .jmp_op_num2_o(jmp_op_num2),
		.jmpb_rs1_o(jmpb_rs1), .jmpb_rs2_o(jmpb_rs2), .load_bypass_o(load_bypass)
	);

	ex_stage core_ex (
		.clk(clk), .arst_n_i(arst_n_i), .alu_operation_i(alu_operation),
		.alu_op_num1_i(alu_op_num1), .alu_op_num2_i(alu_op_num2),
		.store_data_i(store_data), .load_i(load), .store_i(store),
		.addr_wr_i(addr_wr), .reg_wr_en_i(reg_wr_en), .data_mem_i(data_mem_i),
		.alu_result_o(alu_result), .mem_state_o(mem_state_o), .addr_mem_o(addr_mem_o),
		.data_mem_wr_o(data_mem_wr_o), .addr_reg_wr_o(wb_addr),
		.data_reg_wr_o(wb_data), .reg_wr_en_o(wb_en)
	);

	regs general_regs (
		.clk(clk), .arst_n_i(arst_n_i), .wr_en_i(wb_en), .addr_wr_i(wb_addr),
		.addr_rd1_i(addr_rs1), .addr_rd2_i(addr_rs2), .data_wr_i(wb_data),
		.data_rd1_o(data_rs1), .data_rd2_o(data_rs2)
	);

	ctrl core_ctrl (
		.jmp_flag_i(jmp_flag), .jmp_num1_i(jmp_op_num1), .jmp_num2_i(jmp_op_num2),
		.data_rs1_i(jmpb_rs1), .data_rs2_i(jmpb_rs2), .load_bypass_i(load_bypass),
		.jmp_en_o(jmp_en), .jmp_to_o(jmp_to), .instr_mask_o(instr_mask),
		.hold_code_o(hold_code)
	);

endmodule

// ==== sim/tb_core.sv ====
// Testbench for the core
// Instruction and data memory models, directed program tests,
// store strobe checks and a cycle timeout

`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

	localparam logic [31:0] RESET_ADDR = 32'h0000_0080;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 256;
	localparam int BASE_IDX   = RESET_ADDR >> 2;
	// funct3 of ADD, SUB, AND, OR, XOR, SLL, SRL from bit 0 upwards
	localparam logic [20:0] ALU_F3 = {3'b101, 3'b001, 3'b100, 3'b110, 3'b111, 3'b000, 3'b000};

	logic        clk;
	logic        arst_n_i;
	logic [31:0] instr_i, addr_instr_i, data_mem_i;
	mem_state_t  mem_state_o;
	logic        instr_rd_en_o;
	logic [31:0] data_mem_wr_o, addr_mem_o, pc_o;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] program_q[$];
	logic [31:0] exp_addr_q[$], exp_data_q[$];
	logic [31:0] got_addr_q[$], got_data_q[$];
	logic [31:0] rng = 32'ha707;
	int          error_count = 0;
	int          failed_tests = 0;
	int          cycle_count = 0;
	int          cycle_limit = 50;

	core #(.RESET_ADDR(RESET_ADDR)) i_core (
		.clk(clk), .arst_n_i(arst_n_i), .instr_i(instr_i), .addr_instr_i(addr_instr_i),
		.data_mem_i(data_mem_i), .mem_state_o(mem_state_o), .instr_rd_en_o(instr_rd_en_o),
		.data_mem_wr_o(data_mem_wr_o), .addr_mem_o(addr_mem_o), .pc_o(pc_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ************************************************************
	// Memory models
	// ************************************************************
	always @(negedge clk) begin
		instr_i      <= imem[pc_o[7:2]];
		addr_instr_i <= pc_o;
		data_mem_i   <= dmem[addr_mem_o[9:2]];
	end

	always @(posedge clk) begin
		if (arst_n_i && mem_state_o == MEM_WR) begin
			dmem[addr_mem_o[9:2]] <= data_mem_wr_o;
			got_addr_q.push_back(addr_mem_o);
			got_data_q.push_back(data_mem_wr_o);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, the core never reached its halt loop", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ************************************************************
	// Instruction encoding and reference values
	// ************************************************************
	function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_instr(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] jal_instr(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return ((addr >> 2) + 32'd1) * 32'h9e37_79b9;
	endfunction

	function automatic logic [31:0] alu_ref(input int k, input logic [31:0] a,
		input logic [31:0] b);
		case (k)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return a << b[4:0];
			default: return a >> b[4:0];
		endcase
	endfunction

	// ************************************************************
	// Program handling and checks
	// ************************************************************
	task automatic new_program();
		program_q.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	// LUI takes the rounded upper part so the signed ADDI lands on the value
	task automatic emit_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = (value + 32'h800) >> 12;
		program_q.push_back(lui_instr(rd, upper[19:0]));
		program_q.push_back(addi_instr(rd, rd, value[11:0]));
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic run_program();
		int          halt_idx;
		logic [31:0] halt_addr;
		@(negedge clk);
		arst_n_i = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = addi_instr(5'd0, 5'd0, 12'(i));  // NOPs that differ by address
		end
		for (int i = 0; i < program_q.size(); i++) begin
			imem[BASE_IDX + i] = program_q[i];
		end
		halt_idx  = BASE_IDX + program_q.size();
		halt_addr = RESET_ADDR + 32'(4 * program_q.size());
		imem[halt_idx] = jal_instr(5'd0, 21'd0);  // Jump to itself
		cycle_limit += 4 * (program_q.size() + 1);
		repeat (8) @(negedge clk);
		got_addr_q.delete();
		got_data_q.delete();
		assert (pc_o == RESET_ADDR) else begin
			$display("MISMATCH at %0t: pc_o is %h in reset, expected %h", $time, pc_o, RESET_ADDR);
			error_count++;
		end
		assert (mem_state_o == MEM_RD && instr_rd_en_o) else begin
			$display("MISMATCH at %0t: memory port not idle in reset", $time);
			error_count++;
		end
		arst_n_i = 1'b1;
		while (pc_o != halt_addr) @(negedge clk);
		repeat (3) @(negedge clk);  // Let the last instructions leave execute
	endtask

	task automatic check_stores();
		assert (got_addr_q.size() == exp_addr_q.size()) else begin
			$display("MISMATCH at %0t: %0d stores seen, %0d expected", $time,
				got_addr_q.size(), exp_addr_q.size());
			error_count++;
		end
		for (int i = 0; i < exp_addr_q.size() && i < got_addr_q.size(); i++) begin
			assert (got_addr_q[i] == exp_addr_q[i] && got_data_q[i] == exp_data_q[i]) else begin
				$display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h", $time, i,
					got_data_q[i], got_addr_q[i], exp_data_q[i], exp_addr_q[i]);
				error_count++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		run_program();
		check_stores();
		if (error_count == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d checks failed", name, error_count - errs_before);
			failed_tests++;
		end
	endtask

	// ************************************************************
	// Tests
	// ************************************************************
	task automatic alu_ops_test();
		logic [31:0] a, b;
		int          errs_before;
		errs_before = error_count;
		new_program();
		rng = xorshift(rng);
		a   = rng;
		rng = xorshift(rng);
		b   = rng;
		emit_const(5'd1, a);
		emit_const(5'd2, b);
		for (int k = 0; k < 7; k++) begin
			program_q.push_back(r_instr((k == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, ALU_F3[3*k +: 3], 5'd3));
			program_q.push_back(sw_instr(5'd3, 5'd0, 12'h100 + 12'(4 * k)));
			expect_store(32'h100 + 32'(4 * k), alu_ref(k, a, b));
		end
		report_test("alu_ops", errs_before);
	endtask

	task automatic forwarding_test();
		logic [11:0] imm;
		logic [31:0] r5, r6;
		int          errs_before;
		errs_before = error_count;
		new_program();
		rng = xorshift(rng);
		imm = rng[11:0];
		program_q.push_back(addi_instr(5'd5, 5'd0, imm));
		r5 = sext12(imm);
		for (int k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			imm = rng[11:0];
			program_q.push_back(addi_instr(5'd6, 5'd5, imm));
			program_q.push_back(r_instr(7'h00, 5'd5, 5'd6, 3'b000, 5'd5));
			r6 = r5 + sext12(imm);
			r5 = r6 + r5;
		end
		program_q.push_back(sw_instr(5'd5, 5'd0, 12'h120));
		expect_store(32'h120, r5);
		report_test("forwarding", errs_before);
	endtask

	task automatic load_use_test();
		logic [31:0] v;
		logic [11:0] imm;
		int          errs_before;
		errs_before = error_count;
		new_program();
		rng = xorshift(rng);
		v   = rng;
		rng = xorshift(rng);
		imm = rng[11:0];
		emit_const(5'd1, v);
		program_q.push_back(sw_instr(5'd1, 5'd0, 12'h140));
		program_q.push_back(lw_instr(5'd2, 5'd0, 12'h140));
		program_q.push_back(addi_instr(5'd3, 5'd2, imm));  // Needs the load result at once
		program_q.push_back(sw_instr(5'd3, 5'd0, 12'h144));
		program_q.push_back(lw_instr(5'd4, 5'd0, 12'h180));
		program_q.push_back(addi_instr(5'd5, 5'd4, imm));
		program_q.push_back(sw_instr(5'd5, 5'd0, 12'h184));
		expect_store(32'h140, v);
		expect_store(32'h144, v + sext12(imm));
		expect_store(32'h184, fill_word(32'h180) + sext12(imm));
		report_test("load_use", errs_before);
	endtask

	task automatic control_flow_test();
		int errs_before;
		errs_before = error_count;
		new_program();
		program_q.push_back(addi_instr(5'd9, 5'd0, 12'h7ad));  // Marker value
		program_q.push_back(addi_instr(5'd1, 5'd0, 12'd5));
		program_q.push_back(addi_instr(5'd2, 5'd0, 12'd5));
		program_q.push_back(b_instr(3'b000, 5'd1, 5'd2, 13'd12));  // BEQ taken
		program_q.push_back(sw_instr(5'd9, 5'd0, 12'h1a0));
		program_q.push_back(sw_instr(5'd9, 5'd0, 12'h1a0));
		program_q.push_back(b_instr(3'b001, 5'd1, 5'd2, 13'd12));  // BNE falls through
		program_q.push_back(sw_instr(5'd1, 5'd0, 12'h1a4));
		program_q.push_back(jal_instr(5'd7, 21'd12));
		program_q.push_back(sw_instr(5'd9, 5'd0, 12'h1a8));
		program_q.push_back(sw_instr(5'd9, 5'd0, 12'h1a8));
		program_q.push_back(sw_instr(5'd7, 5'd0, 12'h1ac));
		expect_store(32'h1a4, 32'd5);
		expect_store(32'h1ac, RESET_ADDR + 32'd36);  // JAL sits at word 8
		report_test("control_flow", errs_before);
	endtask

	task automatic x0_test();
		int errs_before;
		errs_before = error_count;
		new_program();
		rng = xorshift(rng);
		program_q.push_back(addi_instr(5'd0, 5'd0, rng[11:0] | 12'h001));
		program_q.push_back(sw_instr(5'd0, 5'd0, 12'h1c0));
		expect_store(32'h1c0, 32'd0);
		report_test("x0_zero", errs_before);
	endtask

	// Reset values are checked in every run, here no store may come before the first SW
	task automatic reset_state_test();
		int errs_before;
		errs_before = error_count;
		new_program();
		program_q.push_back(addi_instr(5'd1, 5'd0, 12'h123));
		program_q.push_back(addi_instr(5'd2, 5'd1, 12'h001));
		program_q.push_back(sw_instr(5'd2, 5'd0, 12'h1e0));
		expect_store(32'h1e0, 32'h124);
		report_test("reset_state", errs_before);
	endtask

	initial begin
		arst_n_i     = 1'b0;
		instr_i      = '0;
		addr_instr_i = RESET_ADDR;
		data_mem_i   = '0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(32'(i) * 4);
		end
		alu_ops_test();
		forwarding_test();
		load_use_test();
		control_flow_test();
		x0_test();
		reset_state_test();
		$display("6 tests run, %0d failed, %0d checks failed", failed_tests, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== core.f ====
hw/core_pkg.sv
hw/isa_pkg.sv
hw/pc.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/regs.sv
hw/ctrl.sv
hw/core.sv
sim/tb_core.sv
